// ==== flist.f ====
hdl/vram_blit_pkg.sv
hdl/host_wb_port.sv
hdl/blit_regs.sv
hdl/vram_access.sv
hdl/init_clear.sv
hdl/vram_blit_top.sv
test/vram_model.sv
test/tb_vram_blit.sv

// ==== test/vram_blit_golden.txt ====
# W reg word writes high then low byte, R reg word reads back high then low byte
# H cycles holds slot grants, C addr word checks the next host VRAM write (all hex)
W 0 0003
R 0 0003
W 1 0102
R 1 0102
W 6 0140
R 6 0140
W 3 5a5a
R 3 0000
R c 0000
W 7 4e41
W 7 0742
R 7 0742
R 6 0344
H 20
W 7 1e43
W 7 1e44
R 7 1e44
R 6 0548
W 5 0242
R 8 0742
R 5 0245
W 5 003f
R 8 1f20
R 5 0042
W 5 1234
R 8 9148
C 0140 4e41
C 0242 0742
C 0344 1e43
C 0446 1e44

// ==== test/tb_vram_blit.sv ====
////////////////////////////////////////
// testbench for the VRAM access engine
// runs from the project root, reads
// test/vram_blit_golden.txt
// clear shortened to 64 words
// stops at the first failed check
////////////////////////////////////////

`timescale 1ns/1ns

module tb_vram_blit;

    import vram_blit_pkg::*;

    localparam int unsigned CLEAR_WORDS = 64;
    localparam vram_word_t  CLEAR_DATA  = 16'h1F20;

    logic                 clk = 1'b0;
    logic                 reset_i;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [7:0]           wb_dat_w;
    logic [7:0]           wb_dat_r;
    logic                 wb_ack;
    logic                 blit_cycle;
    logic                 vram_sel;
    logic                 vram_wr;
    vram_addr_t           vram_addr;
    vram_word_t           vram_rdata;
    vram_word_t           vram_wdata;
    logic                 video_ena;
    logic                 hold_grant;
    int unsigned          vram_wr_count;

    logic [7:0]  op_q[$];
    logic [15:0] arg_a_q[$];
    logic [15:0] arg_b_q[$];
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = CLEAR_WORDS * 20;
    int unsigned hold_until  = 0;
    int unsigned launched    = 0;               // VRAM writes started so far
    int unsigned host_idx    = 0;               // next host write in the model log

    always #10 clk = ~clk;

    assign hold_grant = (cycle_cnt < hold_until);

    vram_blit_top #(
        .CLEAR_WORDS (CLEAR_WORDS),
        .CLEAR_DATA  (CLEAR_DATA)
    ) dut_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat_w),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack),
        .blit_cycle_i (blit_cycle),
        .vram_sel_o   (vram_sel),
        .vram_wr_o    (vram_wr),
        .vram_addr_o  (vram_addr),
        .vram_rdata_i (vram_rdata),
        .vram_wdata_o (vram_wdata),
        .video_ena_o  (video_ena)
    );

    vram_model #(
        .SEED (25227)
    ) model_i (
        .clk        (clk),
        .hold_i     (hold_grant),
        .grant_o    (blit_cycle),
        .sel_i      (vram_sel),
        .wr_i       (vram_wr),
        .addr_i     (vram_addr),
        .wdata_i    (vram_wdata),
        .rdata_o    (vram_rdata),
        .wr_count_o (vram_wr_count)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s, got %0h expected %0h",
                                    $time, what, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            stop_on_error($sformatf("Timeout: run did not finish within %0d cycles",
                                    cycle_limit));
        end
    end

    task automatic load_golden();
        int          fd;
        int          c;
        int          n;
        logic [15:0] a;
        logic [15:0] b;
        fd = $fopen("test/vram_blit_golden.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open test/vram_blit_golden.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin                         // comment runs to end of line
                while (c != -1 && c != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (c == "W" || c == "R" || c == "C" || c == "H") begin
                b = '0;
                if (c == "H") begin
                    n = $fscanf(fd, "%h", a) + 1;
                end else begin
                    n = $fscanf(fd, "%h %h", a, b);
                end
                if (n != 2) begin
                    stop_on_error("malformed line in the golden file");
                end
                op_q.push_back(c[7:0]);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                stop_on_error("unknown operation in the golden file");
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // one classic cycle, driven on the rising edge, ack sampled mid cycle
    task automatic bus_cycle(input logic we, input logic [3:0] num, input logic lane,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= {num, lane};
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata = wb_dat_r;
        if (we && lane && (num == DATA)) begin      // earlier writes must already be in VRAM
            check(vram_wr_count, launched, "VRAM writes done when a DATA write was acked");
            launched++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic run_op(input logic [7:0] op, input logic [15:0] a, input logic [15:0] b);
        logic [7:0] rd;
        case (op)
            "W": begin
                bus_cycle(1'b1, a[3:0], 1'b0, b[15:8], rd);     // high byte first
                bus_cycle(1'b1, a[3:0], 1'b1, b[7:0], rd);
            end
            "R": begin
                bus_cycle(1'b0, a[3:0], 1'b0, 8'h00, rd);
                check(rd, b[15:8], $sformatf("register %0h high byte", a[3:0]));
                bus_cycle(1'b0, a[3:0], 1'b1, 8'h00, rd);
                check(rd, b[7:0], $sformatf("register %0h low byte", a[3:0]));
            end
            "H": hold_until = cycle_cnt + a;
            default: begin
                @(negedge clk);
                while (vram_sel) begin
                    @(negedge clk);
                end
                check(model_i.wr_log[host_idx], {a, b},
                      $sformatf("host write %0d address and data", host_idx - CLEAR_WORDS));
                check(model_i.mem[a], b, $sformatf("VRAM word at %04h", a));
                host_idx++;
            end
        endcase
    endtask

    initial begin
        reset_i  = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        load_golden();
        cycle_limit = CLEAR_WORDS * 20 + op_q.size() * 40;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check({wb_ack, vram_sel, vram_wr, video_ena}, 4'b0000, "outputs low in reset");
        end
        @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check({wb_ack, vram_sel, vram_wr, video_ena}, 4'b0000, "outputs low after reset");
        while (!video_ena) begin
            @(negedge clk);
        end
        check(vram_wr_count, CLEAR_WORDS, "clear words written when video enable rose");
        for (int i = 0; i < CLEAR_WORDS; i++) begin
            check(model_i.wr_log[i], {i[15:0], CLEAR_DATA}, $sformatf("clear write %0d", i));
        end
        launched = CLEAR_WORDS;
        host_idx = CLEAR_WORDS;
        for (int i = 0; i < op_q.size(); i++) begin
            run_op(op_q[i], arg_a_q[i], arg_b_q[i]);
        end
        @(negedge clk);
        check(vram_wr_count, launched, "total VRAM writes");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== test/vram_model.sv ====
////////////////////////////////////////
// behavioral VRAM for the testbench
// random slot grant, held off by hold_i
// unwritten words read a fill pattern
// built from the whole address
// wr_log keeps the first LOG_DEPTH writes
////////////////////////////////////////

`timescale 1ns/1ns

module vram_model #(
    parameter int unsigned SEED      = 25227,
    parameter int unsigned LOG_DEPTH = 256
) (
    input  logic                       clk,
    input  logic                       hold_i,
    output logic                       grant_o,
    input  logic                       sel_i,
    input  logic                       wr_i,
    input  vram_blit_pkg::vram_addr_t  addr_i,
    input  vram_blit_pkg::vram_word_t  wdata_i,
    output vram_blit_pkg::vram_word_t  rdata_o,
    output int unsigned                wr_count_o
);

    import vram_blit_pkg::*;

    vram_word_t  mem [0:65535];
    logic [31:0] wr_log [0:LOG_DEPTH-1];        // {address, data} in arrival order

    // one process owns the random stream so the seed covers every draw
    initial begin
        void'($urandom(SEED));
        for (int a = 0; a < 65536; a++) begin
            mem[a] = {a[7:0], a[15:8]} ^ 16'hA55A;     // bytes swapped, then scrambled
        end
        grant_o    = 1'b0;
        rdata_o    = '0;
        wr_count_o = 0;
        forever begin
            @(posedge clk);
            if (sel_i && grant_o) begin                 // slot used by the engine
                if (wr_i) begin
                    mem[addr_i] = wdata_i;
                    if (wr_count_o < LOG_DEPTH) begin
                        wr_log[wr_count_o] = {addr_i, wdata_i};
                    end
                    wr_count_o <= wr_count_o + 1;
                end else begin
                    rdata_o <= mem[addr_i];             // data shows up the cycle after the slot
                end
            end
            grant_o <= !hold_i && (($urandom % 2) == 1);
        end
    end

endmodule

// ==== hdl/vram_blit_top.sv ====
////////////////////////////////////////
// VRAM access engine, top level
// host on 8-bit Wishbone classic
// VRAM shared with video refresh, the
// engine uses only granted slots
// host launches wait for the clear
////////////////////////////////////////

`timescale 1ns/1ns

module vram_blit_top #(
    parameter int unsigned               CLEAR_WORDS = 65536,
    parameter vram_blit_pkg::vram_word_t CLEAR_DATA  = 16'h1F20
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                wb_cyc_i,
    input  logic                                wb_stb_i,
    input  logic                                wb_we_i,
    input  logic [vram_blit_pkg::WB_ADDR_W-1:0] wb_adr_i,
    input  logic [7:0]                          wb_dat_i,
    output logic [7:0]                          wb_dat_o,
    output logic                                wb_ack_o,
    input  logic                                blit_cycle_i,    // 1 = slot for the engine
    output logic                                vram_sel_o,
    output logic                                vram_wr_o,
    output vram_blit_pkg::vram_addr_t           vram_addr_o,
    input  vram_blit_pkg::vram_word_t           vram_rdata_i,
    output vram_blit_pkg::vram_word_t           vram_wdata_o,
    output logic                                video_ena_o
);

    import vram_blit_pkg::*;

    reg_num_t   reg_num;
    host_wr_t   host_wr;
    logic       accept;
    vram_word_t reg_word;
    logic       ready;
    vram_done_t done;
    vram_word_t rd_word;
    vram_req_t  host_req;
    vram_req_t  clear_req;

    host_wb_port port_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .accept_i   (accept),
        .reg_word_i (reg_word),
        .reg_num_o  (reg_num),
        .wr_o       (host_wr)
    );

    blit_regs regs_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_i       (host_wr),
        .reg_num_i  (reg_num),
        .accept_o   (accept),
        .reg_word_o (reg_word),
        .ready_i    (ready),
        .done_i     (done),
        .rd_word_i  (rd_word),
        .req_o      (host_req)
    );

    vram_access access_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .clear_req_i  (clear_req),
        .host_req_i   (host_req),
        .blit_cycle_i (blit_cycle_i),
        .vram_sel_o   (vram_sel_o),
        .vram_wr_o    (vram_wr_o),
        .vram_addr_o  (vram_addr_o),
        .vram_wdata_o (vram_wdata_o),
        .vram_rdata_i (vram_rdata_i),
        .ready_o      (ready),
        .done_o       (done),
        .rd_word_o    (rd_word)
    );

    init_clear #(
        .CLEAR_WORDS (CLEAR_WORDS),
        .CLEAR_DATA  (CLEAR_DATA)
    ) clear_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .done_i      (done),
        .req_o       (clear_req),
        .video_ena_o (video_ena_o)
    );

endmodule

// ==== hdl/init_clear.sv ====
////////////////////////////////////////
// power-up clear, fills CLEAR_WORDS
// words from address 0 with CLEAR_DATA
// video enable rises after the last word
// and stays up until reset
////////////////////////////////////////

`timescale 1ns/1ns

module init_clear #(
    parameter int unsigned               CLEAR_WORDS = 65536,
    parameter vram_blit_pkg::vram_word_t CLEAR_DATA  = 16'h1F20
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  vram_blit_pkg::vram_done_t  done_i,
    output vram_blit_pkg::vram_req_t   req_o,
    output logic                       video_ena_o
);

    import vram_blit_pkg::*;

    localparam int              CNT_W     = $clog2(CLEAR_WORDS + 1);
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(CLEAR_WORDS - 1);

    typedef enum logic [1:0] {CL_START, CL_RUN, CL_IDLE} clear_state_t;

    clear_state_t     state;
    logic [CNT_W-1:0] words;                    // fill words completed
    vram_addr_t       addr;                     // next fill address
    logic             clear_done;

    assign clear_done = done_i.wr_done && !done_i.host;

    // next word goes out in the done cycle of the previous one
    always_comb begin
        req_o.valid = (state == CL_START) ||
                      ((state == CL_RUN) && clear_done && (words != LAST_WORD));
        req_o.wr    = 1'b1;
        req_o.addr  = addr;
        req_o.data  = CLEAR_DATA;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= CL_START;
            words       <= '0;
            addr        <= '0;
            video_ena_o <= 1'b0;
        end else begin
            if (req_o.valid) begin
                addr <= addr + 1'b1;
            end
            case (state)
                CL_START: state <= CL_RUN;
                CL_RUN: begin
                    if (clear_done) begin
                        words <= words + 1'b1;
                        if (words == LAST_WORD) begin
                            state       <= CL_IDLE;
                            video_ena_o <= 1'b1;
                        end
                    end
                end
                default: ;                      // idle until reset
            endcase
        end
    end

endmodule

// ==== hdl/vram_access.sv ====
////////////////////////////////////////
// single VRAM access in flight
// outputs hold until blit_cycle_i grants
// a slot, read data arrives one cycle
// after the slot
// requests only while ready_o is high,
// the clear request has priority
////////////////////////////////////////

`timescale 1ns/1ns

module vram_access (
    input  logic                       clk,
    input  logic                       reset_i,
    input  vram_blit_pkg::vram_req_t   clear_req_i,
    input  vram_blit_pkg::vram_req_t   host_req_i,
    input  logic                       blit_cycle_i,
    output logic                       vram_sel_o,
    output logic                       vram_wr_o,
    output vram_blit_pkg::vram_addr_t  vram_addr_o,
    output vram_blit_pkg::vram_word_t  vram_wdata_o,
    input  vram_blit_pkg::vram_word_t  vram_rdata_i,
    output logic                       ready_o,
    output vram_blit_pkg::vram_done_t  done_o,
    output vram_blit_pkg::vram_word_t  rd_word_o
);

    import vram_blit_pkg::*;

    logic rd_pend;                              // read slot was last cycle
    logic from_host;

    // clear_req_i also keeps the host out between fill words
    assign ready_o = !vram_sel_o && !rd_pend && !clear_req_i.valid;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
            rd_pend    <= 1'b0;
            from_host  <= 1'b0;
            done_o     <= '0;
        end else begin
            done_o  <= '0;
            rd_pend <= 1'b0;
            if (vram_sel_o) begin
                if (blit_cycle_i) begin                 // slot granted, access completes
                    vram_sel_o     <= 1'b0;
                    vram_wr_o      <= 1'b0;
                    done_o.rd_done <= !vram_wr_o;
                    done_o.wr_done <= vram_wr_o;
                    done_o.host    <= from_host;
                    rd_pend        <= !vram_wr_o;
                end
            end else if (clear_req_i.valid) begin
                vram_sel_o <= 1'b1;
                vram_wr_o  <= clear_req_i.wr;
                from_host  <= 1'b0;
            end else if (host_req_i.valid) begin
                vram_sel_o <= 1'b1;
                vram_wr_o  <= host_req_i.wr;
                from_host  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!vram_sel_o) begin
            if (clear_req_i.valid) begin
                vram_addr_o  <= clear_req_i.addr;
                vram_wdata_o <= clear_req_i.data;
            end else if (host_req_i.valid) begin
                vram_addr_o  <= host_req_i.addr;
                vram_wdata_o <= host_req_i.data;
            end
        end
        if (reset_i) begin
            rd_word_o <= '0;
        end else if (rd_pend) begin
            rd_word_o <= vram_rdata_i;          // VRAM drives data the cycle after the slot
        end
    end

    a_hold_until_slot: assert property (
        @(posedge clk) disable iff (reset_i)
        (vram_sel_o && !blit_cycle_i) |=>
            (vram_sel_o && $stable(vram_wr_o) && $stable(vram_addr_o) && $stable(vram_wdata_o))
    ) else $error("VRAM outputs moved before a slot was granted");

    a_host_req_ready: assert property (
        @(posedge clk) disable iff (reset_i)
        host_req_i.valid |-> ready_o
    ) else $error("host request while access path busy");

    a_clear_req_idle: assert property (
        @(posedge clk) disable iff (reset_i)
        clear_req_i.valid |-> (!vram_sel_o && !rd_pend)
    ) else $error("clear request while access path busy");

endmodule

// ==== hdl/blit_regs.sv ====
////////////////////////////////////////
// host register file
// low byte writes to DATA and RD_ADDR
// start a VRAM access, the high byte
// must be written first
// addresses step on the host done pulse
// dropped registers read as zero
////////////////////////////////////////

`timescale 1ns/1ns

module blit_regs (
    input  logic                       clk,
    input  logic                       reset_i,
    input  vram_blit_pkg::host_wr_t    wr_i,
    input  vram_blit_pkg::reg_num_t    reg_num_i,
    output logic                       accept_o,
    output vram_blit_pkg::vram_word_t  reg_word_o,
    input  logic                       ready_i,
    input  vram_blit_pkg::vram_done_t  done_i,
    input  vram_blit_pkg::vram_word_t  rd_word_i,
    output vram_blit_pkg::vram_req_t   req_o
);

    import vram_blit_pkg::*;

    vram_word_t rd_inc;
    vram_word_t wr_inc;
    vram_addr_t rd_addr;
    vram_addr_t wr_addr;
    vram_word_t data_reg;
    logic       needs_ready;

    function automatic vram_word_t put_byte(
        input vram_word_t old_word,
        input logic       odd,
        input logic [7:0] data
    );
        vram_word_t new_word;
        new_word = old_word;
        if (odd) begin
            new_word[7:0] = data;
        end else begin
            new_word[15:8] = data;
        end
        return new_word;
    endfunction

    // launching writes and RD_DATA reads wait for the access path
    assign needs_ready = (reg_num_i == RD_DATA) ||
                         (wr_i.odd && ((reg_num_i == DATA) || (reg_num_i == RD_ADDR)));
    assign accept_o    = ready_i || !needs_ready;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_inc   <= '0;
            wr_inc   <= '0;
            rd_addr  <= '0;
            wr_addr  <= '0;
            data_reg <= '0;
        end else begin
            if (done_i.host && done_i.rd_done) begin
                rd_addr <= rd_addr + rd_inc;
            end
            if (done_i.host && done_i.wr_done) begin
                wr_addr <= wr_addr + wr_inc;
            end
            // a host byte write wins over a step in the same cycle
            if (wr_i.valid) begin
                case (wr_i.num)
                    RD_INC:  rd_inc   <= put_byte(rd_inc, wr_i.odd, wr_i.data);
                    WR_INC:  wr_inc   <= put_byte(wr_inc, wr_i.odd, wr_i.data);
                    RD_ADDR: rd_addr  <= put_byte(rd_addr, wr_i.odd, wr_i.data);
                    WR_ADDR: wr_addr  <= put_byte(wr_addr, wr_i.odd, wr_i.data);
                    DATA:    data_reg <= put_byte(data_reg, wr_i.odd, wr_i.data);
                    default: ;                          // RD_DATA and gaps ignore writes
                endcase
            end
        end
    end

    // access launch, issued in the ack cycle of the low byte write
    always_comb begin
        req_o = '0;
        if (wr_i.valid && wr_i.odd) begin
            if (wr_i.num == DATA) begin
                req_o.valid = 1'b1;
                req_o.wr    = 1'b1;
                req_o.addr  = wr_addr;
                req_o.data  = {data_reg[15:8], wr_i.data};
            end else if (wr_i.num == RD_ADDR) begin
                req_o.valid = 1'b1;
                req_o.wr    = 1'b0;
                req_o.addr  = {rd_addr[15:8], wr_i.data};
            end
        end
    end

    always_comb begin
        case (reg_num_i)
            RD_INC:  reg_word_o = rd_inc;
            WR_INC:  reg_word_o = wr_inc;
            RD_ADDR: reg_word_o = rd_addr;
            WR_ADDR: reg_word_o = wr_addr;
            DATA:    reg_word_o = data_reg;
            RD_DATA: reg_word_o = rd_word_i;
            default: reg_word_o = '0;
        endcase
    end

endmodule

// ==== hdl/host_wb_port.sv ====
////////////////////////////////////////
// Wishbone classic slave, 8-bit data
// one ack pulse per cycle, registered
// wait states while accept_i is low
// host holds adr/dat/we until ack
////////////////////////////////////////

`timescale 1ns/1ns

module host_wb_port (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                wb_cyc_i,
    input  logic                                wb_stb_i,
    input  logic                                wb_we_i,
    input  logic [vram_blit_pkg::WB_ADDR_W-1:0] wb_adr_i,
    input  logic [7:0]                          wb_dat_i,
    output logic [7:0]                          wb_dat_o,
    output logic                                wb_ack_o,
    input  logic                                accept_i,
    input  vram_blit_pkg::vram_word_t           reg_word_i,
    output vram_blit_pkg::reg_num_t             reg_num_o,
    output vram_blit_pkg::host_wr_t             wr_o
);

    import vram_blit_pkg::*;

    logic byte_odd;

    assign reg_num_o = reg_num_t'(wb_adr_i[WB_ADDR_W-1:1]);
    assign byte_odd  = wb_adr_i[0];

    // the byte fields follow the bus at all times, valid marks the write
    always_comb begin
        wr_o.valid = wb_ack_o && wb_we_i;
        wr_o.num   = reg_num_o;
        wr_o.odd   = byte_odd;
        wr_o.data  = wb_dat_i;
    end

    assign wb_dat_o = byte_odd ? reg_word_i[7:0] : reg_word_i[15:8];  // even lane is high byte

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            // single pulse, next cycle the host must drop stb or move on
            wb_ack_o <= wb_cyc_i && wb_stb_i && accept_i && !wb_ack_o;
        end
    end

    // ack only ever answers a live bus cycle
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (reset_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i)
    ) else $error("ack without cyc and stb");

endmodule

// ==== hdl/vram_blit_pkg.sv ====
////////////////////////////////////////
// shared types for the VRAM access engine
// VRAM words are 16 bits, attribute byte
// above character byte
// Wishbone byte 0 is the high (even) byte
// and byte 1 is the low (odd) byte
////////////////////////////////////////

package vram_blit_pkg;

    localparam int WB_ADDR_W = 5;           // adr[4:1] register, adr[0] byte lane

    typedef logic [15:0] vram_addr_t;       // VRAM word address
    typedef logic [15:0] vram_word_t;       // attribute byte above character byte

    // host visible registers, the gaps read as zero
    typedef enum logic [3:0] {
        RD_INC  = 4'd0,                     // read address increment
        WR_INC  = 4'd1,                     // write address increment
        RD_ADDR = 4'd5,                     // low byte write starts a read
        WR_ADDR = 4'd6,                     // VRAM write address
        DATA    = 4'd7,                     // low byte write starts a write
        RD_DATA = 4'd8                      // word fetched by the last read
    } reg_num_t;

    // one host byte write, valid only in the ack cycle
    typedef struct packed {
        logic       valid;
        reg_num_t   num;
        logic       odd;                    // 1 = low byte
        logic [7:0] data;
    } host_wr_t;

    // one VRAM access request
    typedef struct packed {
        logic       valid;
        logic       wr;                     // 1 = write, 0 = read
        vram_addr_t addr;
        vram_word_t data;                   // write data, unused on reads
    } vram_req_t;

    // completion pulses, one cycle wide
    typedef struct packed {
        logic rd_done;
        logic wr_done;
        logic host;                         // access was started by the host
    } vram_done_t;

endpackage
